// ==== cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath widths
`define XLEN        64
`define ILEN        32

// Integer register file geometry
`define REG_ADDR_W  5
`define NUM_REGS    32

// First fetch address out of reset
`define RESET_PC    64'h0

// Major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

`endif

// ==== cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`XLEN-1:0]       addr_t;
    typedef logic [`ILEN-1:0]       instr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [0:0] {
        OPND2_REG,
        OPND2_IMM
    } opnd2_src_e;

    // Fetch to decode
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_pkt_t;

    // Decode to issue
    typedef struct packed {
        addr_t      pc;
        alu_op_e    alu_op;
        opnd2_src_e opnd2_src;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;
        logic       wb_en;
    } uop_t;

    // Issue to integer pipe
    typedef struct packed {
        addr_t    pc;
        alu_op_e  alu_op;
        word_t    operand1;
        word_t    operand2;
        reg_idx_t rd;
        logic     wb_en;
    } exec_pkt_t;

    // One committed instruction
    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     wb_en;
    } retire_t;

endpackage

// ==== ifp.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module ifp
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // Instruction memory
    output addr_t      im_req_addr,
    output logic       im_req_valid,
    input  logic       im_req_ready,
    input  instr_t     im_resp_rdata,
    input  logic       im_resp_valid,
    // Decoder side
    output logic       if_dec_valid,
    input  logic       if_dec_ready,
    output fetch_pkt_t if_dec
);

    addr_t pc;
    addr_t req_pc;
    logic  outstanding;
    logic  req_fire;

    // Only request when the reply is sure to find the buffer empty
    assign im_req_valid = !outstanding && (!if_dec_valid || if_dec_ready);
    assign im_req_addr  = pc;
    assign req_fire     = im_req_valid && im_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `RESET_PC;
            outstanding <= 1'b0;
        end else if (req_fire) begin
            pc          <= pc + addr_t'(`ILEN / 8);
            outstanding <= 1'b1;
        end else if (im_resp_valid) begin
            outstanding <= 1'b0;
        end
    end

    // Tag kept for the single request in flight
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_pc <= pc;
        end
    end

    // One-entry output buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            if_dec_valid <= 1'b0;
        end else if (im_resp_valid) begin
            if_dec_valid <= 1'b1;
        end else if (if_dec_ready) begin
            if_dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (im_resp_valid) begin
            if_dec.pc    <= req_pc;
            if_dec.instr <= im_resp_rdata;
        end
    end

endmodule

// ==== dec.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module dec
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // Fetch side
    input  logic       if_dec_valid,
    output logic       if_dec_ready,
    input  fetch_pkt_t if_dec,
    // Issue side
    output logic       dec_ix_valid,
    input  logic       dec_ix_ready,
    output uop_t       dec_ix
);

    instr_t     instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       supported;
    uop_t       uop;

    assign instr  = if_dec.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        supported     = 1'b1;
        uop.pc        = if_dec.pc;
        uop.alu_op    = ALU_ADD;
        uop.opnd2_src = OPND2_IMM;
        uop.rs1       = instr[19:15];
        uop.rs2       = '0;
        uop.rd        = instr[11:7];
        // I-type immediate by default
        uop.imm       = {{(`XLEN - 12){instr[31]}}, instr[31:20]};
        case (opcode)
            `OPC_OP: begin
                uop.opnd2_src = OPND2_REG;
                uop.rs2       = instr[24:20];
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: uop.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: uop.alu_op = ALU_SUB;
                    {7'b0000000, 3'b001}: uop.alu_op = ALU_SLL;
                    {7'b0000000, 3'b100}: uop.alu_op = ALU_XOR;
                    {7'b0000000, 3'b101}: uop.alu_op = ALU_SRL;
                    {7'b0000000, 3'b110}: uop.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: uop.alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  uop.alu_op = ALU_ADD;
                    3'b100:  uop.alu_op = ALU_XOR;
                    3'b110:  uop.alu_op = ALU_OR;
                    3'b111:  uop.alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                uop.alu_op = ALU_PASS_B;
                uop.rs1    = '0;
                uop.imm    = {{(`XLEN - 32){instr[31]}}, instr[31:12], 12'b0};
            end
            default: supported = 1'b0;
        endcase
        // Anything else goes down the pipe as a no-op touching no register
        if (!supported) begin
            uop.alu_op    = ALU_ADD;
            uop.opnd2_src = OPND2_IMM;
            uop.rs1       = '0;
            uop.rs2       = '0;
            uop.rd        = '0;
            uop.imm       = '0;
        end
        uop.wb_en = supported && (uop.rd != '0);
    end

    assign if_dec_ready = !dec_ix_valid || dec_ix_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_ix_valid <= 1'b0;
        end else if (if_dec_ready) begin
            dec_ix_valid <= if_dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_dec_valid && if_dec_ready) begin
            dec_ix <= uop;
        end
    end

endmodule

// ==== ix.sv ====
`timescale 1ns/1ps

module ix
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Decode side
    input  logic      dec_ix_valid,
    output logic      dec_ix_ready,
    input  uop_t      dec_ix,
    // Register file reads
    output reg_idx_t  rf_rsrc0,
    output reg_idx_t  rf_rsrc1,
    input  word_t     rf_rdata0,
    input  word_t     rf_rdata1,
    // Integer pipe side
    output logic      ix_ip_valid,
    input  logic      ix_ip_ready,
    output exec_pkt_t ix_ip,
    // Commit feedback
    input  logic      retire_valid,
    input  retire_t   retire
);

    logic [2**$bits(reg_idx_t)-1:0] pending;
    logic [2**$bits(reg_idx_t)-1:0] clr_mask;
    logic [2**$bits(reg_idx_t)-1:0] set_mask;
    logic [2**$bits(reg_idx_t)-1:0] busy;
    logic hazard;
    logic out_free;
    logic dispatch;

    assign rf_rsrc0 = dec_ix.rs1;
    assign rf_rsrc1 = dec_ix.rs2;

    // A register retiring this cycle is already readable through rf bypass
    always_comb begin
        clr_mask = '0;
        if (retire_valid && retire.wb_en) begin
            clr_mask[retire.rd] = 1'b1;
        end
    end

    assign busy   = pending & ~clr_mask;
    assign hazard = busy[dec_ix.rs1]
                 || (dec_ix.opnd2_src == OPND2_REG && busy[dec_ix.rs2])
                 || (dec_ix.wb_en && busy[dec_ix.rd]);

    assign out_free     = !ix_ip_valid || ix_ip_ready;
    assign dec_ix_ready = out_free && !hazard;
    assign dispatch     = dec_ix_valid && dec_ix_ready;

    always_comb begin
        set_mask = '0;
        if (dispatch && dec_ix.wb_en) begin
            set_mask[dec_ix.rd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending     <= '0;
            ix_ip_valid <= 1'b0;
        end else begin
            pending <= busy | set_mask;
            if (out_free) begin
                ix_ip_valid <= dispatch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            ix_ip.pc       <= dec_ix.pc;
            ix_ip.alu_op   <= dec_ix.alu_op;
            ix_ip.operand1 <= rf_rdata0;
            ix_ip.operand2 <= (dec_ix.opnd2_src == OPND2_IMM) ? dec_ix.imm : rf_rdata1;
            ix_ip.rd       <= dec_ix.rd;
            ix_ip.wb_en    <= dec_ix.wb_en;
        end
    end

endmodule

// ==== rf.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module rf
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rf_rsrc0,
    input  reg_idx_t rf_rsrc1,
    output word_t    rf_rdata0,
    output word_t    rf_rdata1,
    input  logic     retire_valid,
    input  retire_t  retire
);

    word_t regs [`NUM_REGS];
    logic  wen;

    // x0 reads zero, a same-cycle write is seen by the read
    function automatic word_t read_port(input reg_idx_t idx, input word_t stored,
                                        input logic we, input reg_idx_t wdst,
                                        input word_t wdata);
        if (idx == '0) begin
            return '0;
        end
        return (we && wdst == idx) ? wdata : stored;
    endfunction

    assign wen = retire_valid && retire.wb_en && (retire.rd != '0);

    assign rf_rdata0 = read_port(rf_rsrc0, regs[rf_rsrc0], wen, retire.rd, retire.value);
    assign rf_rdata1 = read_port(rf_rsrc1, regs[rf_rsrc1], wen, retire.rd, retire.value);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[retire.rd] <= retire.value;
        end
    end

endmodule

// ==== ip.sv ====
`timescale 1ns/1ps

module ip
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // From issue
    input  logic      ix_ip_valid,
    output logic      ix_ip_ready,
    input  exec_pkt_t ix_ip,
    // Commit
    output logic      retire_valid,
    output retire_t   retire
);

    word_t result;
    logic  accept;

    // Single-cycle ALU, never stalls
    assign ix_ip_ready = 1'b1;
    assign accept      = ix_ip_valid && ix_ip_ready;

    always_comb begin
        case (ix_ip.alu_op)
            ALU_ADD:    result = ix_ip.operand1 + ix_ip.operand2;
            ALU_SUB:    result = ix_ip.operand1 - ix_ip.operand2;
            ALU_AND:    result = ix_ip.operand1 & ix_ip.operand2;
            ALU_OR:     result = ix_ip.operand1 | ix_ip.operand2;
            ALU_XOR:    result = ix_ip.operand1 ^ ix_ip.operand2;
            // RV64 shifts use the low 6 bits
            ALU_SLL:    result = ix_ip.operand1 << ix_ip.operand2[5:0];
            ALU_SRL:    result = ix_ip.operand1 >> ix_ip.operand2[5:0];
            ALU_PASS_B: result = ix_ip.operand2;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            retire.pc    <= ix_ip.pc;
            retire.rd    <= ix_ip.rd;
            retire.value <= result;
            retire.wb_en <= ix_ip.wb_en;
        end
    end

endmodule

// ==== cpu.sv ====
`timescale 1ns/1ps

module cpu
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    // Instruction memory
    output addr_t   im_req_addr,
    output logic    im_req_valid,
    input  logic    im_req_ready,
    input  instr_t  im_resp_rdata,
    input  logic    im_resp_valid,
    // Commit stream
    output logic    retire_valid,
    output retire_t retire
);

    // Fetch to decode
    logic       if_dec_valid;
    logic       if_dec_ready;
    fetch_pkt_t if_dec;

    ifp ifp (
        .clk(clk),
        .rst(rst),
        .im_req_addr(im_req_addr),
        .im_req_valid(im_req_valid),
        .im_req_ready(im_req_ready),
        .im_resp_rdata(im_resp_rdata),
        .im_resp_valid(im_resp_valid),
        .if_dec_valid(if_dec_valid),
        .if_dec_ready(if_dec_ready),
        .if_dec(if_dec)
    );

    // Decode to issue
    logic dec_ix_valid;
    logic dec_ix_ready;
    uop_t dec_ix;

    dec dec (
        .clk(clk),
        .rst(rst),
        .if_dec_valid(if_dec_valid),
        .if_dec_ready(if_dec_ready),
        .if_dec(if_dec),
        .dec_ix_valid(dec_ix_valid),
        .dec_ix_ready(dec_ix_ready),
        .dec_ix(dec_ix)
    );

    // Register file read ports
    reg_idx_t rf_rsrc0;
    reg_idx_t rf_rsrc1;
    word_t    rf_rdata0;
    word_t    rf_rdata1;

    // Issue to integer pipe
    logic      ix_ip_valid;
    logic      ix_ip_ready;
    exec_pkt_t ix_ip;

    ix ix (
        .clk(clk),
        .rst(rst),
        .dec_ix_valid(dec_ix_valid),
        .dec_ix_ready(dec_ix_ready),
        .dec_ix(dec_ix),
        .rf_rsrc0(rf_rsrc0),
        .rf_rsrc1(rf_rsrc1),
        .rf_rdata0(rf_rdata0),
        .rf_rdata1(rf_rdata1),
        .ix_ip_valid(ix_ip_valid),
        .ix_ip_ready(ix_ip_ready),
        .ix_ip(ix_ip),
        .retire_valid(retire_valid),
        .retire(retire)
    );

    rf rf (
        .clk(clk),
        .rst(rst),
        .rf_rsrc0(rf_rsrc0),
        .rf_rsrc1(rf_rsrc1),
        .rf_rdata0(rf_rdata0),
        .rf_rdata1(rf_rdata1),
        .retire_valid(retire_valid),
        .retire(retire)
    );

    ip ip0 (
        .clk(clk),
        .rst(rst),
        .ix_ip_valid(ix_ip_valid),
        .ix_ip_ready(ix_ip_ready),
        .ix_ip(ix_ip),
        .retire_valid(retire_valid),
        .retire(retire)
    );

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu
    import cpu_pkg::*;
();

    localparam int N_INSTR        = 400;
    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = N_INSTR * 10;

    logic    clk;
    logic    rst;
    addr_t   im_req_addr;
    logic    im_req_valid;
    logic    im_req_ready;
    instr_t  im_resp_rdata;
    logic    im_resp_valid;
    logic    retire_valid;
    retire_t retire;

    instr_t      program_mem [N_INSTR];
    retire_t     expected    [N_INSTR];
    word_t       model_regs  [`NUM_REGS];
    logic [31:0] lcg_state   = 32'd2789;
    int          ret_count   = 0;
    int          retire_errs = 0;
    int          value_errs  = 0;

    cpu dut (
        .clk(clk),
        .rst(rst),
        .im_req_addr(im_req_addr),
        .im_req_valid(im_req_valid),
        .im_req_ready(im_req_ready),
        .im_resp_rdata(im_resp_rdata),
        .im_resp_valid(im_resp_valid),
        .retire_valid(retire_valid),
        .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Upper half only, the low LCG bits repeat too quickly
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic word_t sext12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    function automatic instr_t encode_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                            input reg_idx_t rd, input reg_idx_t rs1,
                                            input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic instr_t encode_itype(input logic [2:0] f3, input reg_idx_t rd,
                                            input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    // Generates the program and runs the reference model alongside it
    task automatic build_program();
        logic [15:0] kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        word_t       a;
        word_t       b;
        word_t       res;
        instr_t      ins;
        for (int r = 0; r < `NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < N_INSTR; i++) begin
            // Only x0..x7 so dependencies are frequent
            kind  = next_rand() % 20;
            rd    = reg_idx_t'(next_rand() % 8);
            rs1   = reg_idx_t'(next_rand() % 8);
            rs2   = reg_idx_t'(next_rand() % 8);
            imm12 = 12'(next_rand());
            imm20 = 20'({next_rand(), next_rand()});
            a     = model_regs[rs1];
            b     = model_regs[rs2];
            res   = '0;
            case (kind)
                // Branch opcode, outside the subset
                0:        ins = {imm20, 5'(next_rand()), 7'b1100011};
                1, 2: begin
                    ins = encode_rtype(7'h00, 3'b000, rd, rs1, rs2);
                    res = a + b;
                end
                3: begin
                    ins = encode_rtype(7'h20, 3'b000, rd, rs1, rs2);
                    res = a - b;
                end
                4: begin
                    ins = encode_rtype(7'h00, 3'b111, rd, rs1, rs2);
                    res = a & b;
                end
                5: begin
                    ins = encode_rtype(7'h00, 3'b110, rd, rs1, rs2);
                    res = a | b;
                end
                6: begin
                    ins = encode_rtype(7'h00, 3'b100, rd, rs1, rs2);
                    res = a ^ b;
                end
                7: begin
                    ins = encode_rtype(7'h00, 3'b001, rd, rs1, rs2);
                    res = a << b[5:0];
                end
                8: begin
                    ins = encode_rtype(7'h00, 3'b101, rd, rs1, rs2);
                    res = a >> b[5:0];
                end
                9, 10, 11: begin
                    ins = encode_itype(3'b000, rd, rs1, imm12);
                    res = a + sext12(imm12);
                end
                12: begin
                    ins = encode_itype(3'b111, rd, rs1, imm12);
                    res = a & sext12(imm12);
                end
                13, 14: begin
                    ins = encode_itype(3'b110, rd, rs1, imm12);
                    res = a | sext12(imm12);
                end
                15, 16: begin
                    ins = encode_itype(3'b100, rd, rs1, imm12);
                    res = a ^ sext12(imm12);
                end
                default: begin
                    ins = {imm20, rd, `OPC_LUI};
                    res = {{32{imm20[19]}}, imm20, 12'h000};
                end
            endcase
            program_mem[i]    = ins;
            expected[i].pc    = addr_t'(i * 4);
            expected[i].rd    = rd;
            expected[i].value = res;
            expected[i].wb_en = (kind != 0) && (rd != '0);
            if (expected[i].wb_en) begin
                model_regs[rd] = res;
            end
        end
    endtask

    function automatic instr_t fetch_word(input addr_t addr);
        if (addr[1:0] == 2'b00 && (addr >> 2) < N_INSTR) begin
            return program_mem[addr >> 2];
        end
        // Past the end the core just sees nops
        return 32'h0000_0013;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            $display("ERR %0t: instruction %0d value %h, expected %h", $time, idx, got, exp);
            value_errs++;
        end
    endtask

    // rd and value only matter when the instruction writes
    task automatic check_retire(input retire_t got, input retire_t exp, input int idx);
        logic bad;
        bad = (got.pc !== exp.pc) || (got.wb_en !== exp.wb_en);
        if (exp.wb_en && got.rd !== exp.rd) begin
            bad = 1'b1;
        end
        if (bad) begin
            $display("ERR %0t: retire %0d pc=%h rd=%0d wb_en=%b, expected pc=%h rd=%0d wb_en=%b",
                     $time, idx, got.pc, got.rd, got.wb_en, exp.pc, exp.rd, exp.wb_en);
            retire_errs++;
        end
        if (exp.wb_en) begin
            check_word(got.value, exp.value, idx);
        end
    endtask

    // Instruction memory with random ready and 1 to 3 cycle response delay
    initial begin : memory_model
        int    resp_wait;
        logic  took;
        addr_t taken_addr;
        im_req_ready  = 1'b0;
        im_resp_valid = 1'b0;
        im_resp_rdata = '0;
        resp_wait     = 0;
        taken_addr    = '0;
        forever begin
            @(posedge clk);
            took = !rst && im_req_valid && im_req_ready;
            if (took) begin
                taken_addr = im_req_addr;
            end
            #1;
            im_resp_valid = 1'b0;
            if (took) begin
                resp_wait = 1 + next_rand() % 3;
            end else if (resp_wait > 0) begin
                resp_wait--;
                if (resp_wait == 0) begin
                    im_resp_valid = 1'b1;
                    im_resp_rdata = fetch_word(taken_addr);
                end
            end
            im_req_ready = (next_rand() % 4) != 0;
        end
    end

    always @(posedge clk) begin
        if (!rst && retire_valid && ret_count < N_INSTR) begin
            check_retire(retire, expected[ret_count], ret_count);
            ret_count++;
        end
    end

    initial begin
        rst = 1'b1;
        build_program();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        wait (ret_count == N_INSTR);
        repeat (2) @(posedge clk);
        $display("Retired %0d of %0d, retire errors %0d, value errors %0d",
                 ret_count, N_INSTR, retire_errs, value_errs);
        if (retire_errs == 0 && value_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Core hung: only %0d of %0d instructions retired within %0d cycles",
                 ret_count, N_INSTR, TIMEOUT_CYCLES);
        $display("Retire errors %0d, value errors %0d", retire_errs, value_errs);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
cpu_pkg.sv
ifp.sv
dec.sv
ix.sv
rf.sv
ip.sv
cpu.sv
tb_cpu.sv
